/* hdl/dispatch_router.sv */
`timescale 1ns/1ps

module dispatch_router (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  flush,
    input  logic                                  stall_in,
    input  logic                                  disp_valid,
    input  iq_pkg::op_class_t                     disp_class,
    input  iq_pkg::preg_t                         disp_pj,
    input  logic                                  disp_need_j,
    input  logic                                  disp_rdy_j,
    input  iq_pkg::preg_t                         disp_pk,
    input  logic                                  disp_need_k,
    input  logic                                  disp_rdy_k,
    input  iq_pkg::preg_t                         disp_pd,
    input  logic                                  disp_regwr,
    input  logic [3:0]                            disp_conf,
    input  logic                                  disp_is_imm,
    input  logic [31:0]                           disp_imm,
    input  iq_pkg::rob_tag_t                      disp_tag,
    input  iq_pkg::rob_tag_t                      ptr_old,
    input  logic                                  alu_full,
    input  logic                                  mdu_full,
    input  logic [iq_pkg::NUM_CDB-1:0]            cdb_valid,
    input  iq_pkg::preg_t [iq_pkg::NUM_CDB-1:0]   cdb_pd,
    output logic                                  disp_accept,
    output logic                                  alu_ins,
    output logic                                  mdu_ins,
    output iq_pkg::preg_t                         ins_pj,
    output iq_pkg::preg_t                         ins_pk,
    output logic                                  ins_rdy_j,
    output logic                                  ins_rdy_k,
    output iq_pkg::alu_payload_t                  alu_payload,
    output iq_pkg::mdu_payload_t                  mdu_payload,
    output iq_pkg::rob_tag_t                      ptr_old_q
);
    import iq_pkg::*;

    logic is_alu;
    logic target_full;
    logic byp_j;
    logic byp_k;

    assign is_alu      = (disp_class == CLASS_ALU);
    assign target_full = is_alu ? alu_full : mdu_full;
    assign disp_accept = disp_valid && !stall_in && !flush && !target_full;
    assign alu_ins     = disp_accept && is_alu;
    assign mdu_ins     = disp_accept && !is_alu;

    // a broadcast in the dispatch cycle is gone once the entry lands
    always_comb begin
        byp_j = 1'b0;
        byp_k = 1'b0;
        for (int l = 0; l < NUM_CDB; l++) begin
            byp_j = byp_j | (cdb_valid[l] && (cdb_pd[l] == disp_pj));
            byp_k = byp_k | (cdb_valid[l] && (cdb_pd[l] == disp_pk));
        end
    end

    assign ins_pj    = disp_pj;
    assign ins_pk    = disp_pk;
    assign ins_rdy_j = !disp_need_j || disp_rdy_j || byp_j;
    assign ins_rdy_k = !disp_need_k || disp_rdy_k || byp_k;

    assign alu_payload = '{conf: disp_conf, pd: disp_pd, regwr: disp_regwr,
                           is_imm: disp_is_imm, imm: disp_imm, tag: disp_tag,
                           spare: 2'b00};
    assign mdu_payload = '{conf: disp_conf, pd: disp_pd, regwr: disp_regwr,
                           tag: disp_tag};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ptr_old_q <= '0;
        end else begin
            ptr_old_q <= ptr_old;
        end
    end

    a_one_target: assert property (@(posedge clk) disable iff (!rst)
        !(alu_ins && mdu_ins))
        else $error("dispatch_router: instruction routed to both queues");

endmodule

/* hdl/iq_pkg.sv */
package iq_pkg;

    // physical register number and ROB entry tag
    typedef logic [5:0] preg_t;
    typedef logic [5:0] rob_tag_t;

    typedef enum logic {
        CLASS_ALU = 1'b0,
        CLASS_MDU = 1'b1
    } op_class_t;

    // lane 0 carries ALU results, lane 1 carries MDU results
    localparam int NUM_CDB = 2;
    localparam int CDB_ALU = 0;
    localparam int CDB_MDU = 1;

    // cycles from MDU issue to its broadcast
    localparam int MDU_LATENCY = 3;

    // 52 bits
    typedef struct packed {
        logic [3:0]  conf;
        preg_t       pd;
        logic        regwr;
        logic        is_imm;
        logic [31:0] imm;
        rob_tag_t    tag;
        logic [1:0]  spare;
    } alu_payload_t;

    // 17 bits
    typedef struct packed {
        logic [3:0] conf;
        preg_t      pd;
        logic       regwr;
        rob_tag_t   tag;
    } mdu_payload_t;

    // age relative to the oldest in-flight ROB entry
    function automatic rob_tag_t tag_age(rob_tag_t tag, rob_tag_t oldest);
        return rob_tag_t'(tag - oldest);
    endfunction

endpackage

/* hdl/issue_cluster.sv */
`timescale 1ns/1ps

module issue_cluster #(
    parameter int ALU_DEPTH = 8,
    parameter int MDU_DEPTH = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   flush,
    input  logic                                   stall_in,
    input  logic                                   disp_valid,
    input  iq_pkg::op_class_t                      disp_class,
    input  iq_pkg::preg_t                          disp_pj,
    input  logic                                   disp_need_j,
    input  logic                                   disp_rdy_j,
    input  iq_pkg::preg_t                          disp_pk,
    input  logic                                   disp_need_k,
    input  logic                                   disp_rdy_k,
    input  iq_pkg::preg_t                          disp_pd,
    input  logic                                   disp_regwr,
    input  logic [3:0]                             disp_conf,
    input  logic                                   disp_is_imm,
    input  logic [31:0]                            disp_imm,
    input  iq_pkg::rob_tag_t                       disp_tag,
    input  iq_pkg::rob_tag_t                       ptr_old,
    output logic                                   disp_accept,
    output logic                                   alu_full,
    output logic                                   mdu_full,
    output logic                                   alu_iss_valid,
    output iq_pkg::rob_tag_t                       alu_iss_tag,
    output logic                                   mdu_iss_valid,
    output iq_pkg::rob_tag_t                       mdu_iss_tag,
    output logic [iq_pkg::NUM_CDB-1:0]             cdb_valid,
    output iq_pkg::preg_t [iq_pkg::NUM_CDB-1:0]    cdb_pd,
    output iq_pkg::rob_tag_t [iq_pkg::NUM_CDB-1:0] cdb_tag
);
    import iq_pkg::*;

    logic         alu_ins;
    logic         mdu_ins;
    preg_t        ins_pj;
    preg_t        ins_pk;
    logic         ins_rdy_j;
    logic         ins_rdy_k;
    alu_payload_t alu_payload;
    mdu_payload_t mdu_payload;
    rob_tag_t     ptr_old_q;
    alu_payload_t alu_iss_payload;
    mdu_payload_t mdu_iss_payload;

    assign alu_iss_tag = alu_iss_payload.tag;
    assign mdu_iss_tag = mdu_iss_payload.tag;

    dispatch_router u_router (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .stall_in    (stall_in),
        .disp_valid  (disp_valid),
        .disp_class  (disp_class),
        .disp_pj     (disp_pj),
        .disp_need_j (disp_need_j),
        .disp_rdy_j  (disp_rdy_j),
        .disp_pk     (disp_pk),
        .disp_need_k (disp_need_k),
        .disp_rdy_k  (disp_rdy_k),
        .disp_pd     (disp_pd),
        .disp_regwr  (disp_regwr),
        .disp_conf   (disp_conf),
        .disp_is_imm (disp_is_imm),
        .disp_imm    (disp_imm),
        .disp_tag    (disp_tag),
        .ptr_old     (ptr_old),
        .alu_full    (alu_full),
        .mdu_full    (mdu_full),
        .cdb_valid   (cdb_valid),
        .cdb_pd      (cdb_pd),
        .disp_accept (disp_accept),
        .alu_ins     (alu_ins),
        .mdu_ins     (mdu_ins),
        .ins_pj      (ins_pj),
        .ins_pk      (ins_pk),
        .ins_rdy_j   (ins_rdy_j),
        .ins_rdy_k   (ins_rdy_k),
        .alu_payload (alu_payload),
        .mdu_payload (mdu_payload),
        .ptr_old_q   (ptr_old_q)
    );

    wakeup_queue #(
        .DEPTH     (ALU_DEPTH),
        .payload_t (alu_payload_t)
    ) u_aluq (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .ins         (alu_ins),
        .ins_pj      (ins_pj),
        .ins_pk      (ins_pk),
        .ins_rdy_j   (ins_rdy_j),
        .ins_rdy_k   (ins_rdy_k),
        .ins_payload (alu_payload),
        .ins_tag     (disp_tag),
        .ptr_old     (ptr_old_q),
        .cdb_valid   (cdb_valid),
        .cdb_pd      (cdb_pd),
        .full        (alu_full),
        .iss_valid   (alu_iss_valid),
        .iss_payload (alu_iss_payload)
    );

    wakeup_queue #(
        .DEPTH     (MDU_DEPTH),
        .payload_t (mdu_payload_t)
    ) u_mduq (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .ins         (mdu_ins),
        .ins_pj      (ins_pj),
        .ins_pk      (ins_pk),
        .ins_rdy_j   (ins_rdy_j),
        .ins_rdy_k   (ins_rdy_k),
        .ins_payload (mdu_payload),
        .ins_tag     (disp_tag),
        .ptr_old     (ptr_old_q),
        .cdb_valid   (cdb_valid),
        .cdb_pd      (cdb_pd),
        .full        (mdu_full),
        .iss_valid   (mdu_iss_valid),
        .iss_payload (mdu_iss_payload)
    );

    result_bus u_cdb (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .alu_iss_valid   (alu_iss_valid),
        .alu_iss_payload (alu_iss_payload),
        .mdu_iss_valid   (mdu_iss_valid),
        .mdu_iss_payload (mdu_iss_payload),
        .cdb_valid       (cdb_valid),
        .cdb_pd          (cdb_pd),
        .cdb_tag         (cdb_tag)
    );

endmodule

/* hdl/result_bus.sv */
`timescale 1ns/1ps

module result_bus (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   flush,
    input  logic                                   alu_iss_valid,
    input  iq_pkg::alu_payload_t                   alu_iss_payload,
    input  logic                                   mdu_iss_valid,
    input  iq_pkg::mdu_payload_t                   mdu_iss_payload,
    output logic [iq_pkg::NUM_CDB-1:0]             cdb_valid,
    output iq_pkg::preg_t [iq_pkg::NUM_CDB-1:0]    cdb_pd,
    output iq_pkg::rob_tag_t [iq_pkg::NUM_CDB-1:0] cdb_tag
);
    import iq_pkg::*;

    logic                        alu_v_q;
    preg_t                       alu_pd_q;
    rob_tag_t                    alu_tag_q;

    logic [MDU_LATENCY-1:0]      mdu_v_q;
    preg_t    [MDU_LATENCY-1:0]  mdu_pd_q;
    rob_tag_t [MDU_LATENCY-1:0]  mdu_tag_q;

    // valid bits only, ops without regwr never reach the lane
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            alu_v_q <= 1'b0;
            mdu_v_q <= '0;
        end else if (flush) begin
            alu_v_q <= 1'b0;
            mdu_v_q <= '0;
        end else begin
            alu_v_q <= alu_iss_valid && alu_iss_payload.regwr;
            mdu_v_q <= {mdu_v_q[MDU_LATENCY-2:0],
                        mdu_iss_valid && mdu_iss_payload.regwr};
        end
    end

    always_ff @(posedge clk) begin
        alu_pd_q  <= alu_iss_payload.pd;
        alu_tag_q <= alu_iss_payload.tag;
        mdu_pd_q  <= {mdu_pd_q[MDU_LATENCY-2:0], mdu_iss_payload.pd};
        mdu_tag_q <= {mdu_tag_q[MDU_LATENCY-2:0], mdu_iss_payload.tag};
    end

    assign cdb_valid[CDB_ALU] = alu_v_q;
    assign cdb_pd[CDB_ALU]    = alu_pd_q;
    assign cdb_tag[CDB_ALU]   = alu_tag_q;

    assign cdb_valid[CDB_MDU] = mdu_v_q[MDU_LATENCY-1];
    assign cdb_pd[CDB_MDU]    = mdu_pd_q[MDU_LATENCY-1];
    assign cdb_tag[CDB_MDU]   = mdu_tag_q[MDU_LATENCY-1];

    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst)
        flush |=> (cdb_valid == '0))
        else $error("result_bus: broadcast right after flush");

endmodule

/* hdl/wakeup_queue.sv */
`timescale 1ns/1ps

module wakeup_queue #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = logic [15:0]
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  flush,
    input  logic                                  ins,
    input  iq_pkg::preg_t                         ins_pj,
    input  iq_pkg::preg_t                         ins_pk,
    input  logic                                  ins_rdy_j,
    input  logic                                  ins_rdy_k,
    input  payload_t                              ins_payload,
    input  iq_pkg::rob_tag_t                      ins_tag,
    input  iq_pkg::rob_tag_t                      ptr_old,
    input  logic [iq_pkg::NUM_CDB-1:0]            cdb_valid,
    input  iq_pkg::preg_t [iq_pkg::NUM_CDB-1:0]   cdb_pd,
    output logic                                  full,
    output logic                                  iss_valid,
    output payload_t                              iss_payload
);
    import iq_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0] ent_valid;
    logic [DEPTH-1:0] ent_rdy_j;
    logic [DEPTH-1:0] ent_rdy_k;
    preg_t            ent_pj  [DEPTH];
    preg_t            ent_pk  [DEPTH];
    rob_tag_t         ent_tag [DEPTH];
    payload_t         ent_pl  [DEPTH];
    rob_tag_t         ent_age [DEPTH];

    logic [DEPTH-1:0] hit_j;
    logic [DEPTH-1:0] hit_k;
    logic [DEPTH-1:0] req;

    logic [IDX_W-1:0] ins_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             sel_any;
    rob_tag_t         best_age;

    assign full = &ent_valid;

    // result bus compare, one per entry and source
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            hit_j[i] = 1'b0;
            hit_k[i] = 1'b0;
            for (int l = 0; l < NUM_CDB; l++) begin
                hit_j[i] = hit_j[i] | (cdb_valid[l] && (cdb_pd[l] == ent_pj[i]));
                hit_k[i] = hit_k[i] | (cdb_valid[l] && (cdb_pd[l] == ent_pk[i]));
            end
            req[i]     = ent_valid[i] && (ent_rdy_j[i] || hit_j[i])
                                      && (ent_rdy_k[i] || hit_k[i]);
            ent_age[i] = tag_age(ent_tag[i], ptr_old);
        end
    end

    // lowest free slot
    always_comb begin
        ins_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                ins_idx = IDX_W'(i);
            end
        end
    end

    // oldest ready entry wins
    always_comb begin
        sel_any  = 1'b0;
        sel_idx  = '0;
        best_age = '1;
        for (int i = 0; i < DEPTH; i++) begin
            if (req[i] && (!sel_any || (ent_age[i] < best_age))) begin
                sel_any  = 1'b1;
                sel_idx  = IDX_W'(i);
                best_age = ent_age[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ent_valid <= '0;
            iss_valid <= 1'b0;
        end else if (flush) begin
            ent_valid <= '0;
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= sel_any;
            if (sel_any) begin
                ent_valid[sel_idx] <= 1'b0;
            end
            if (ins) begin
                ent_valid[ins_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (ins && (ins_idx == IDX_W'(i))) begin
                ent_pj[i]    <= ins_pj;
                ent_pk[i]    <= ins_pk;
                ent_rdy_j[i] <= ins_rdy_j;
                ent_rdy_k[i] <= ins_rdy_k;
                ent_tag[i]   <= ins_tag;
                ent_pl[i]    <= ins_payload;
            end else begin
                // sticky once the producer has broadcast
                ent_rdy_j[i] <= ent_rdy_j[i] | hit_j[i];
                ent_rdy_k[i] <= ent_rdy_k[i] | hit_k[i];
            end
        end
        if (sel_any) begin
            iss_payload <= ent_pl[sel_idx];
        end
    end

    a_no_ins_full: assert property (@(posedge clk) disable iff (!rst)
        ins |-> !full)
        else $error("wakeup_queue: insert while full");

    a_src_ready: assert property (@(posedge clk) disable iff (!rst)
        sel_any |-> ent_valid[sel_idx]
                    && (ent_rdy_j[sel_idx] || hit_j[sel_idx])
                    && (ent_rdy_k[sel_idx] || hit_k[sel_idx]))
        else $error("wakeup_queue: issue with an unready source");

endmodule

/* list.f */
hdl/iq_pkg.sv
hdl/dispatch_router.sv
hdl/wakeup_queue.sv
hdl/result_bus.sv
hdl/issue_cluster.sv
verification/issue_cluster_checks.sv
verification/issue_cluster_tb.sv

/* verification/issue_cluster_checks.sv */
`timescale 1ns/1ps

module issue_cluster_checks (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   flush,
    input  logic                                   disp_accept,
    input  iq_pkg::op_class_t                      disp_class,
    input  iq_pkg::rob_tag_t                       disp_tag,
    input  iq_pkg::preg_t                          disp_pj,
    input  logic                                   disp_need_j,
    input  logic                                   disp_rdy_j,
    input  iq_pkg::preg_t                          disp_pk,
    input  logic                                   disp_need_k,
    input  logic                                   disp_rdy_k,
    input  iq_pkg::preg_t                          disp_pd,
    input  logic                                   disp_regwr,
    input  iq_pkg::rob_tag_t                       ptr_old,
    input  logic                                   alu_full,
    input  logic                                   mdu_full,
    input  logic                                   alu_iss_valid,
    input  iq_pkg::rob_tag_t                       alu_iss_tag,
    input  logic                                   mdu_iss_valid,
    input  iq_pkg::rob_tag_t                       mdu_iss_tag,
    input  logic [iq_pkg::NUM_CDB-1:0]             cdb_valid,
    input  iq_pkg::preg_t [iq_pkg::NUM_CDB-1:0]    cdb_pd,
    input  iq_pkg::rob_tag_t [iq_pkg::NUM_CDB-1:0] cdb_tag
);
    import iq_pkg::*;

    int          errors = 0;
    // scoreboard of outstanding tags, one bit per tag
    logic [63:0] waiting;
    logic [63:0] is_mdu;
    logic [63:0] regwr_of;
    logic [63:0] live_j;
    logic [63:0] live_k;
    preg_t       src_j [64];
    preg_t       src_k [64];
    preg_t       pd_of [64];
    rob_tag_t    ptr_q;
    logic        exp_alu_v;
    logic        exp_mdu_v;
    rob_tag_t    exp_alu_tag;
    rob_tag_t    exp_mdu_tag;

    task automatic report(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    function automatic logic cdb_hit(input preg_t p);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < NUM_CDB; l++) begin
            hit = hit | (cdb_valid[l] && (cdb_pd[l] == p));
        end
        return hit;
    endfunction

    // {found, tag} of the oldest entry with both sources ready
    function automatic logic [6:0] oldest_ready(input logic mdu);
        logic     found;
        rob_tag_t best;
        rob_tag_t age;
        rob_tag_t best_age;
        found    = 1'b0;
        best     = '0;
        best_age = '1;
        for (int t = 0; t < 64; t++) begin
            age = rob_tag_t'(t) - ptr_q;
            if (waiting[t] && (is_mdu[t] == mdu) && !live_j[t] && !live_k[t]
                    && (!found || (age < best_age))) begin
                found    = 1'b1;
                best     = rob_tag_t'(t);
                best_age = age;
            end
        end
        return {found, best};
    endfunction

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            waiting   = '0;
            live_j    = '0;
            live_k    = '0;
            exp_alu_v = 1'b0;
            exp_mdu_v = 1'b0;
            ptr_q     = '0;
        end else begin
            if (alu_iss_valid !== exp_alu_v || (exp_alu_v && alu_iss_tag !== exp_alu_tag)) begin
                report($sformatf("ALU issue valid %0b tag %0d, expected valid %0b tag %0d",
                                 alu_iss_valid, alu_iss_tag, exp_alu_v, exp_alu_tag));
            end
            if (mdu_iss_valid !== exp_mdu_v || (exp_mdu_v && mdu_iss_tag !== exp_mdu_tag)) begin
                report($sformatf("MDU issue valid %0b tag %0d, expected valid %0b tag %0d",
                                 mdu_iss_valid, mdu_iss_tag, exp_mdu_v, exp_mdu_tag));
            end
            if (alu_iss_valid) begin
                waiting[alu_iss_tag] = 1'b0;
            end
            if (mdu_iss_valid) begin
                waiting[mdu_iss_tag] = 1'b0;
            end
            if (flush) begin
                waiting   = '0;
                exp_alu_v = 1'b0;
                exp_mdu_v = 1'b0;
            end else begin
                // wakeup from this cycle's broadcasts
                for (int t = 0; t < 64; t++) begin
                    if (live_j[t] && cdb_hit(src_j[t])) begin
                        live_j[t] = 1'b0;
                    end
                    if (live_k[t] && cdb_hit(src_k[t])) begin
                        live_k[t] = 1'b0;
                    end
                end
                {exp_alu_v, exp_alu_tag} = oldest_ready(1'b0);
                {exp_mdu_v, exp_mdu_tag} = oldest_ready(1'b1);
                if (disp_accept) begin
                    if (waiting[disp_tag]) begin
                        report($sformatf("tag %0d accepted while still queued", disp_tag));
                    end
                    waiting[disp_tag]  = 1'b1;
                    is_mdu[disp_tag]   = (disp_class == CLASS_MDU);
                    regwr_of[disp_tag] = disp_regwr;
                    pd_of[disp_tag]    = disp_pd;
                    src_j[disp_tag]    = disp_pj;
                    src_k[disp_tag]    = disp_pk;
                    live_j[disp_tag]   = disp_need_j && !disp_rdy_j && !cdb_hit(disp_pj);
                    live_k[disp_tag]   = disp_need_k && !disp_rdy_k && !cdb_hit(disp_pk);
                end
            end
            ptr_q = ptr_old;
        end
    end

    a_alu_lane: assert property (@(posedge clk) disable iff (!rst || flush)
        alu_iss_valid && regwr_of[alu_iss_tag]
        |=> cdb_valid[CDB_ALU] && (cdb_tag[CDB_ALU] == $past(alu_iss_tag))
            && (cdb_pd[CDB_ALU] == $past(pd_of[alu_iss_tag])))
        else report("wrong or missing ALU result on lane 0 one cycle after issue");

    a_alu_quiet: assert property (@(posedge clk) disable iff (!rst || flush)
        !(alu_iss_valid && regwr_of[alu_iss_tag]) |=> !cdb_valid[CDB_ALU])
        else report("lane 0 valid without an ALU issue that writes a register");

    a_mdu_lane: assert property (@(posedge clk) disable iff (!rst || flush)
        mdu_iss_valid && regwr_of[mdu_iss_tag]
        |-> ##MDU_LATENCY cdb_valid[CDB_MDU]
            && (cdb_tag[CDB_MDU] == $past(mdu_iss_tag, MDU_LATENCY))
            && (cdb_pd[CDB_MDU] == $past(pd_of[mdu_iss_tag], MDU_LATENCY)))
        else report("wrong or missing MDU result on lane 1 after its latency");

    a_mdu_quiet: assert property (@(posedge clk) disable iff (!rst || flush)
        !(mdu_iss_valid && regwr_of[mdu_iss_tag]) |-> ##MDU_LATENCY !cdb_valid[CDB_MDU])
        else report("lane 1 valid without an MDU issue that writes a register");

    a_flush_clear: assert property (@(posedge clk) disable iff (!rst)
        flush |=> !alu_iss_valid && !mdu_iss_valid && !alu_full && !mdu_full
                  && (cdb_valid == '0))
        else report("cluster not empty after flush");

endmodule

/* verification/issue_cluster_tb.sv */
`timescale 1ns/1ps

module issue_cluster_tb;
    import iq_pkg::*;

    localparam int TIMEOUT = 100;

    logic clk;
    logic rst;
    logic flush;
    logic stall_in;
    logic disp_valid;
    op_class_t disp_class;
    preg_t disp_pj;
    logic disp_need_j;
    logic disp_rdy_j;
    preg_t disp_pk;
    logic disp_need_k;
    logic disp_rdy_k;
    preg_t disp_pd;
    logic disp_regwr;
    logic [3:0] disp_conf;
    logic disp_is_imm;
    logic [31:0] disp_imm;
    rob_tag_t disp_tag;
    rob_tag_t ptr_old;
    logic disp_accept;
    logic alu_full;
    logic mdu_full;
    logic alu_iss_valid;
    rob_tag_t alu_iss_tag;
    logic mdu_iss_valid;
    rob_tag_t mdu_iss_tag;
    logic [NUM_CDB-1:0] cdb_valid;
    preg_t [NUM_CDB-1:0] cdb_pd;
    rob_tag_t [NUM_CDB-1:0] cdb_tag;

    logic [31:0] lfsr = 32'h70a0_c61b;
    // busy table, a register stays busy until its broadcast
    logic [63:0] busy;
    int cyc;
    int acc_cyc;
    int tb_errors = 0;
    int timeouts = 0;
    rob_tag_t next_tag;

    issue_cluster u_dut (.*);
    issue_cluster_checks u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #2_000_000;
        $display("watchdog expired before the test sequence finished");
        $display(">>> FAIL");
        $finish;
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy = '0;
            cyc  = 0;
        end else begin
            cyc++;
            if (flush) begin
                busy = '0;
            end else begin
                for (int l = 0; l < NUM_CDB; l++) begin
                    if (cdb_valid[l]) begin
                        busy[cdb_pd[l]] = 1'b0;
                    end
                end
                if (disp_accept && disp_regwr) begin
                    busy[disp_pd] = 1'b1;
                end
            end
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic note_error(input string msg);
        tb_errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic drive_op(input op_class_t cls, input logic need_j, input preg_t pj,
                            input logic need_k, input preg_t pk, input logic regwr);
        disp_valid  = 1'b1;
        disp_class  = cls;
        disp_tag    = next_tag;
        disp_pd     = next_tag;
        disp_pj     = pj;
        disp_pk     = pk;
        disp_need_j = need_j;
        disp_need_k = need_k;
        disp_regwr  = regwr;
        disp_conf   = next_tag[3:0];
        disp_is_imm = !need_k;
        disp_imm    = {26'd0, next_tag};
    endtask

    // hold the instruction until it is accepted
    task automatic dispatch(input op_class_t cls, input logic need_j, input preg_t pj,
                            input logic need_k, input preg_t pk, input logic regwr);
        int   waited;
        logic acc;
        waited = 0;
        acc    = 1'b0;
        drive_op(cls, need_j, pj, need_k, pk, regwr);
        while (!acc && waited < TIMEOUT) begin
            disp_rdy_j = !busy[pj];
            disp_rdy_k = !busy[pk];
            @(negedge clk);
            acc = disp_accept;
            @(posedge clk);
            #2;
            waited++;
        end
        disp_valid = 1'b0;
        if (acc) begin
            acc_cyc  = cyc;
            next_tag = next_tag + 1'b1;
        end else begin
            timeouts++;
            $display("timeout: instruction with tag %0d was never accepted", next_tag);
        end
    endtask

    task automatic expect_blocked(input op_class_t cls, input int n);
        drive_op(cls, 1'b0, '0, 1'b0, '0, 1'b1);
        disp_rdy_j = 1'b1;
        disp_rdy_k = 1'b1;
        repeat (n) begin
            @(negedge clk);
            if (disp_accept) begin
                note_error("instruction accepted into a full queue");
            end
            @(posedge clk);
            #2;
        end
        disp_valid = 1'b0;
    endtask

    task automatic wait_result(input int lane, input rob_tag_t tag, output int lat);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        lat    = -1;
        while (!seen && waited < TIMEOUT) begin
            @(negedge clk);
            seen = cdb_valid[lane] && (cdb_tag[lane] == tag);
            waited++;
        end
        if (seen) begin
            lat = cyc - acc_cyc + 1;
        end else begin
            timeouts++;
            $display("timeout: no broadcast of tag %0d on lane %0d", tag, lane);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((u_chk.waiting != '0 || busy != '0) && waited < TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (waited >= TIMEOUT) begin
            timeouts++;
            $display("timeout: cluster did not drain");
        end
        repeat (MDU_LATENCY + 2) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        int          lat;
        logic [31:0] v;
        logic [31:0] nj;
        logic [31:0] nk;
        logic [31:0] sj;
        logic [31:0] sk;
        logic [31:0] rw;
        rob_tag_t    m;
        preg_t       stuck;
        rst         = 1'b0;
        flush       = 1'b0;
        stall_in    = 1'b0;
        disp_valid  = 1'b0;
        disp_class  = CLASS_ALU;
        disp_pj     = '0;
        disp_need_j = 1'b0;
        disp_rdy_j  = 1'b0;
        disp_pk     = '0;
        disp_need_k = 1'b0;
        disp_rdy_k  = 1'b0;
        disp_pd     = '0;
        disp_regwr  = 1'b0;
        disp_conf   = '0;
        disp_is_imm = 1'b0;
        disp_imm    = '0;
        disp_tag    = '0;
        ptr_old     = '0;
        next_tag    = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b1;
        @(posedge clk);
        #2;

        // idle latency, ALU then MDU
        dispatch(CLASS_ALU, 1'b0, '0, 1'b0, '0, 1'b1);
        wait_result(CDB_ALU, next_tag - 1'b1, lat);
        if (lat != 3) begin
            note_error($sformatf("ALU dispatch to broadcast %0d cycles, expected 3", lat));
        end
        wait_idle();
        dispatch(CLASS_MDU, 1'b0, '0, 1'b0, '0, 1'b1);
        wait_result(CDB_MDU, next_tag - 1'b1, lat);
        if (lat != 5) begin
            note_error($sformatf("MDU dispatch to broadcast %0d cycles, expected 5", lat));
        end
        wait_idle();

        // random mix with dependencies on recent destinations
        ptr_old = next_tag;
        repeat (40) begin
            take_bits(1, v);
            take_bits(1, nj);
            take_bits(3, sj);
            take_bits(1, nk);
            take_bits(3, sk);
            take_bits(3, rw);
            dispatch(op_class_t'(v[0]), nj[0], preg_t'(next_tag - 1'b1 - sj[5:0]),
                     nk[0], preg_t'(next_tag - 1'b1 - sk[5:0]), rw[2:0] != 3'd0);
        end
        wait_idle();

        // back-pressure behind an MDU op that never wakes
        ptr_old = next_tag;
        stuck   = preg_t'(next_tag + 6'd30);
        busy[stuck] = 1'b1;
        m = next_tag;
        dispatch(CLASS_MDU, 1'b1, stuck, 1'b0, '0, 1'b1);
        repeat (8) begin
            dispatch(CLASS_ALU, 1'b1, m, 1'b0, '0, 1'b1);
        end
        @(negedge clk);
        if (!alu_full) begin
            note_error("alu_full low with eight waiting ALU ops");
        end
        @(posedge clk);
        #2;
        expect_blocked(CLASS_ALU, 5);
        dispatch(CLASS_MDU, 1'b0, '0, 1'b0, '0, 1'b1);
        repeat (8) begin
            @(posedge clk);
            #2;
        end

        // flush clears the stuck ops
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        repeat (8) begin
            @(posedge clk);
            #2;
        end
        if (alu_full || mdu_full) begin
            note_error("full flag set after flush");
        end

        // age order across the tag wrap
        ptr_old  = 6'd62;
        next_tag = 6'd62;
        @(posedge clk);
        #2;
        m = next_tag;
        dispatch(CLASS_MDU, 1'b0, '0, 1'b0, '0, 1'b1);
        repeat (4) begin
            dispatch(CLASS_ALU, 1'b1, m, 1'b0, '0, 1'b1);
        end
        wait_idle();

        $display("errors: %0d checker, %0d testbench, %0d timeouts",
                 u_chk.errors, tb_errors, timeouts);
        if (u_chk.errors + tb_errors + timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
